//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - common/fetch_pkg.sv
  - hw/imem_sram.sv
  - hw/fetch/fetch_stage.sv
  - hw/fetch/branch_predictor.sv
  - hw/fetch_ctrl.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - testbench/tb_fetch_top.sv

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ====================
    // datapath widths
    // ====================

    typedef logic [31:0] pc_t;     // byte address, also the program counter
    typedef logic [31:0] instr_t;  // one raw 32-bit instruction word

    // ====================
    // control fsm
    // ====================

    // idle waits for a load or a start, run is left only by reset
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,  // loader owns the sram port
        ST_RUN  = 2'd2   // fetching
    } ctrl_state_e;

    // ====================
    // constants
    // ====================

    localparam pc_t RESET_PC = 32'h0000_0000;  // first fetched address

    // major opcodes seen by the static predictor
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu

endpackage

`default_nettype wire

//--- hw/fetch/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
    input  logic              valid_i,        // instr_i/pc_i hold a real fetch
    input  fetch_pkg::pc_t    pc_i,
    input  fetch_pkg::instr_t instr_i,
    output logic              taken_o,
    output fetch_pkg::pc_t    redirect_pc_o   // zero when not taken
);

    // ====================
    // decode
    // ====================

    logic [6:0]     opcode;
    logic           is_jal;
    logic           is_branch;
    fetch_pkg::pc_t imm_j;   // sign extended jal offset
    fetch_pkg::pc_t imm_b;   // sign extended branch offset

    assign opcode    = instr_i[6:0];
    assign is_jal    = valid_i && (opcode == fetch_pkg::OPC_JAL);
    assign is_branch = valid_i && (opcode == fetch_pkg::OPC_BRANCH);

    // j-type: imm[20|10:1|11|19:12]
    assign imm_j = {{11{instr_i[31]}},
                    instr_i[31],
                    instr_i[19:12],
                    instr_i[20],
                    instr_i[30:21],
                    1'b0};

    // b-type: imm[12|10:5] ... imm[4:1|11]
    assign imm_b = {{19{instr_i[31]}},
                    instr_i[31],
                    instr_i[7],
                    instr_i[30:25],
                    instr_i[11:8],
                    1'b0};

    // ====================
    // prediction
    // ====================

    // jal always taken, btfn for conditional branches
    always_comb begin
        taken_o       = 1'b0;
        redirect_pc_o = '0;
        if (is_jal) begin
            taken_o       = 1'b1;
            redirect_pc_o = pc_i + imm_j;
        end else if (is_branch && imm_b[31]) begin  // negative offset, backward
            taken_o       = 1'b1;
            redirect_pc_o = pc_i + imm_b;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           resetn,
    input  logic           fetch_en_i,     // advance one pc this cycle
    // redirection from the static predictor
    input  logic           taken_i,
    input  fetch_pkg::pc_t redirect_pc_i,
    // sram read address with the data back next cycle
    output fetch_pkg::pc_t rd_addr_o,
    // registered outputs towards decode
    output fetch_pkg::pc_t pc_o,
    output fetch_pkg::pc_t pc_plus4_o
);

    // ====================
    // next pc selection
    // ====================

    localparam fetch_pkg::pc_t PC_STEP = 32'd4;

    fetch_pkg::pc_t pc_q;      // sequential next pc which is pc_o + 4
    fetch_pkg::pc_t next_pc;   // pc delivered on the next enabled edge

    // predicted-taken instruction on the outputs wins over sequential flow
    assign next_pc = taken_i ? redirect_pc_i : pc_q;

    // re-read the held pc during a stall so instr stays aligned with pc_o
    assign rd_addr_o = fetch_en_i ? next_pc : pc_o;

    // ====================
    // pc and output regs
    // ====================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q       <= fetch_pkg::RESET_PC;  // first fetch comes from here
            pc_o       <= '0;
            pc_plus4_o <= '0;
        end else if (fetch_en_i) begin
            pc_o       <= next_pc;              // sram data for it lands next cycle
            pc_plus4_o <= next_pc + PC_STEP;
            pc_q       <= next_pc + PC_STEP;
        end
    end

    // ====================
    // checks
    // ====================

    // redirect targets and the reset pc must keep word alignment
    a_rd_addr_aligned: assert property (
        @(posedge clk) disable iff (!resetn)
        fetch_en_i |-> (rd_addr_o[1:0] == 2'b00)
    ) else $error("fetch_stage: unaligned read address %h", rd_addr_o);

endmodule

`default_nettype wire

//--- hw/fetch_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic start_i,     // pulse seen only in idle
    input  logic stall_i,     // back-pressure level
    input  logic load_we_i,   // loader write strobe
    output logic fetch_en_o,
    output logic valid_o,
    output logic load_sel_o   // hands the sram port to the loader
);

    fetch_pkg::ctrl_state_e state_q;
    fetch_pkg::ctrl_state_e state_d;
    logic                   valid_q;

    // ====================
    // state machine
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::ST_IDLE: begin
                if (load_we_i) begin               // loading has priority over start
                    state_d = fetch_pkg::ST_LOAD;
                end else if (start_i) begin
                    state_d = fetch_pkg::ST_RUN;
                end
            end
            fetch_pkg::ST_LOAD: begin
                if (!load_we_i) begin
                    state_d = fetch_pkg::ST_IDLE;  // burst finished
                end
            end
            fetch_pkg::ST_RUN: state_d = fetch_pkg::ST_RUN;  // left only by reset
            default: state_d = fetch_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= fetch_pkg::ST_IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fetch_en_o) begin
                valid_q <= 1'b1;  // first enabled cycle put RESET_PC on the sram
            end
        end
    end

    // ====================
    // outputs
    // ====================

    assign fetch_en_o = (state_q == fetch_pkg::ST_RUN) && !stall_i;
    assign valid_o    = valid_q;
    // first write of a burst arrives while still idle
    assign load_sel_o = (state_q == fetch_pkg::ST_LOAD)
                     || ((state_q == fetch_pkg::ST_IDLE) && load_we_i);

    a_valid_only_in_run: assert property (
        @(posedge clk) disable iff (!resetn)
        valid_o |-> (state_q == fetch_pkg::ST_RUN)
    ) else $error("fetch_ctrl: valid_o high in state %s", state_q.name());

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
    parameter int IMEM_DEPTH = 1024
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start_i,
    input  logic              stall_i,
    // program loader
    input  logic              load_we_i,
    input  fetch_pkg::pc_t    load_addr_i,
    input  fetch_pkg::instr_t load_data_i,
    // towards decode
    output fetch_pkg::instr_t instr_o,
    output fetch_pkg::pc_t    pc_o,
    output fetch_pkg::pc_t    pc_plus4_o,
    output logic              valid_o
);

    logic           fetch_en;
    logic           valid;
    logic           load_sel;
    logic           taken;
    fetch_pkg::pc_t redirect_pc;
    fetch_pkg::pc_t rd_addr;     // fetch side read address
    fetch_pkg::pc_t sram_addr;
    logic           sram_we;

    // ====================
    // sram port mux
    // ====================

    assign sram_addr = load_sel ? load_addr_i : rd_addr;
    assign sram_we   = load_sel && load_we_i;  // fetch side never writes
    assign valid_o   = valid;

    fetch_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start_i    (start_i),
        .stall_i    (stall_i),
        .load_we_i  (load_we_i),
        .fetch_en_o (fetch_en),
        .valid_o    (valid),
        .load_sel_o (load_sel)
    );

    fetch_stage u_stage (
        .clk           (clk),
        .resetn        (resetn),
        .fetch_en_i    (fetch_en),
        .taken_i       (taken),
        .redirect_pc_i (redirect_pc),
        .rd_addr_o     (rd_addr),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4_o)
    );

    // predicts on the instruction currently on the outputs
    branch_predictor u_bp (
        .valid_i       (valid),
        .pc_i          (pc_o),
        .instr_i       (instr_o),
        .taken_o       (taken),
        .redirect_pc_o (redirect_pc)
    );

    imem_sram #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .clk     (clk),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .wdata_i (load_data_i),
        .rdata_o (instr_o)       // read latency matches the pc register
    );

endmodule

`default_nettype wire

//--- hw/imem_sram.sv
`timescale 1ns/10ps
`default_nettype none

module imem_sram #(
    parameter int IMEM_DEPTH = 1024  // number of 32-bit words
) (
    input  logic              clk,
    input  logic              we_i,     // write strobe from the loader
    input  fetch_pkg::pc_t    addr_i,   // byte address, low two bits ignored
    input  fetch_pkg::instr_t wdata_i,
    output fetch_pkg::instr_t rdata_o   // word at addr_i, one cycle later
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    fetch_pkg::instr_t mem [IMEM_DEPTH];
    fetch_pkg::pc_t    word_addr;  // byte address shifted down to words
    logic [IDX_W-1:0]  idx;

    assign word_addr = addr_i >> 2;
    assign idx       = word_addr[IDX_W-1:0];

    // single port, read-first on a write cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
        rdata_o <= mem[idx];  // registered read
    end

    // upper address bits are dropped by idx, so an out-of-range access would alias
    a_idx_in_range: assert property (
        @(posedge clk) !$isunknown(addr_i) |-> (word_addr < IMEM_DEPTH)
    ) else $error("imem_sram: address %h beyond %0d words", addr_i, IMEM_DEPTH);

endmodule

`default_nettype wire

//--- tb.f
common/fetch_pkg.sv
hw/imem_sram.sv
hw/fetch/fetch_stage.sv
hw/fetch/branch_predictor.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
testbench/tb_fetch_top.sv

//--- testbench/tb_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top;

    localparam int DRV     = 10;  // drive and sample offset after the rising edge
    localparam int TIMEOUT = 20;  // cycles allowed for valid_o to rise
    localparam int MAXW    = 64;  // words per test program

    logic              clk;
    logic              resetn;
    logic              start_i;
    logic              stall_i;
    logic              load_we_i;
    fetch_pkg::pc_t    load_addr_i;
    fetch_pkg::instr_t load_data_i;
    fetch_pkg::instr_t instr_o;
    fetch_pkg::pc_t    pc_o;
    fetch_pkg::pc_t    pc_plus4_o;
    logic              valid_o;

    fetch_pkg::instr_t prog_mem [MAXW];  // program image as loaded
    fetch_pkg::pc_t    next_of  [MAXW];  // expected successor of each word
    int prog_len;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    fetch_top #(.IMEM_DEPTH(1024)) u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .start_i     (start_i),
        .stall_i     (stall_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .instr_o     (instr_o),
        .pc_o        (pc_o),
        .pc_plus4_o  (pc_plus4_o),
        .valid_o     (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // ====================
    // compare tasks
    // ====================

    task automatic check_pc(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp,
                            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_instr(input fetch_pkg::instr_t got, input fetch_pkg::instr_t exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // ====================
    // program assembly
    // ====================

    // each put task records the successor that the static rule predicts
    task automatic put_filler(input int i);
        fetch_pkg::instr_t w;
        w = $urandom;
        w[6:0] = 7'b0010011;  // op-imm opcode never redirects
        prog_mem[i] = w;
        next_of[i]  = (i + 1) * 4;
    endtask

    task automatic put_jal(input int i, input int off);
        logic [20:0] imm;
        imm = off[20:0];
        prog_mem[i] = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, fetch_pkg::OPC_JAL};
        next_of[i]  = i * 4 + off;
    endtask

    task automatic put_branch(input int i, input int off);
        logic [12:0] imm;
        fetch_pkg::instr_t r;
        imm = off[12:0];
        r   = $urandom;  // random rs1, rs2 and funct3
        prog_mem[i] = {imm[12], imm[10:5], r[24:20], r[19:15], r[14:12], imm[4:1], imm[11],
                       fetch_pkg::OPC_BRANCH};
        next_of[i]  = (off < 0) ? i * 4 + off : i * 4 + 4;
    endtask

    // ====================
    // drivers
    // ====================

    task automatic apply_reset();
        resetn    = 1'b0;
        start_i   = 1'b0;
        stall_i   = 1'b0;
        load_we_i = 1'b0;
        repeat (16) @(posedge clk);
        #DRV resetn = 1'b1;
    endtask

    // idle checks ride along with every load cycle
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            load_we_i   = 1'b1;
            load_addr_i = i * 4;
            load_data_i = prog_mem[i];
            @(posedge clk);
            #DRV;
            check_flag(valid_o, 1'b0, "valid_o during load");
            check_pc(pc_o, 32'd0, "pc_o during load");
        end
        load_we_i = 1'b0;
        @(posedge clk);  // back to idle
        #DRV;
    endtask

    task automatic start_fetch(output bit ok);
        int lat;
        lat = 0;
        start_i = 1'b1;
        @(posedge clk);
        #DRV start_i = 1'b0;
        check_flag(valid_o, 1'b0, "valid_o in first run cycle");
        while (!valid_o && lat < TIMEOUT) begin
            @(posedge clk);
            #DRV lat++;
        end
        ok = valid_o;
        if (!ok) begin
            $display("timeout: valid_o did not rise within %0d cycles of start", TIMEOUT);
            errors++;
        end else begin
            check_flag(lat == 1, 1'b1, "first valid one cycle after first run cycle");
        end
    endtask

    // walks the model sequence where a stalled cycle shows the same pc again
    task automatic run_and_check(input int n, input bit use_stall);
        fetch_pkg::pc_t exp_pc;
        int got;
        bit s;
        exp_pc = fetch_pkg::RESET_PC;
        got    = 0;
        while (got < n) begin
            check_flag(valid_o, 1'b1, "valid_o while running");
            check_pc(pc_o, exp_pc, "pc_o");
            check_pc(pc_plus4_o, exp_pc + 4, "pc_plus4_o");
            check_instr(instr_o, prog_mem[exp_pc >> 2], "instr_o");
            s = use_stall && ($urandom % 3 == 0);
            stall_i = s;
            if (!s) begin
                exp_pc = next_of[exp_pc >> 2];
                got++;
            end
            @(posedge clk);
            #DRV;
        end
        stall_i = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("%s: %s, %0d errors", name, (errors == test_errors) ? "passed" : "failed",
                 errors - test_errors);
        test_errors = errors;
    endtask

    // ====================
    // tests
    // ====================

    task automatic test_idle_and_load();
        apply_reset();
        repeat (4) begin
            @(posedge clk);
            #DRV;
            check_flag(valid_o, 1'b0, "valid_o before start");
            check_pc(pc_o, 32'd0, "pc_o before start");
        end
        prog_len = 8;
        for (int i = 0; i < 7; i++) put_filler(i);
        put_jal(7, 0);
        load_program();
        finish_test("idle_and_load");
    endtask

    task automatic test_sequential();
        bit ok;
        apply_reset();
        prog_len = 24;
        for (int i = 0; i < 23; i++) put_filler(i);
        put_jal(23, 0);  // parks fetch on itself
        load_program();
        start_fetch(ok);
        if (ok) run_and_check(20, 1'b0);
        finish_test("sequential");
    endtask

    task automatic test_jal();
        bit ok;
        apply_reset();
        prog_len = 10;
        for (int i = 0; i < 10; i++) put_filler(i);
        put_jal(2, 16);   // forward jump over 3..5
        put_jal(7, -28);  // back to 0
        load_program();
        start_fetch(ok);
        if (ok) run_and_check(12, 1'b0);
        finish_test("jal");
    endtask

    task automatic test_branches();
        bit ok;
        apply_reset();
        prog_len = 8;
        for (int i = 0; i < 8; i++) put_filler(i);
        put_branch(1, 12);  // forward branch falls through
        put_branch(5, -8);  // backward loop over 3..5
        load_program();
        start_fetch(ok);
        if (ok) run_and_check(12, 1'b0);
        finish_test("branches");
    endtask

    task automatic test_stalls();
        bit ok;
        apply_reset();
        prog_len = 8;
        for (int i = 0; i < 8; i++) put_filler(i);
        put_branch(1, 8);
        put_jal(3, 12);
        put_branch(7, -28);
        load_program();
        start_fetch(ok);
        if (ok) run_and_check(40, 1'b1);
        finish_test("stalls");
    endtask

    initial begin
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(26334));
        load_addr_i  = '0;
        load_data_i  = '0;
        apply_reset();
        test_idle_and_load();
        test_sequential();
        test_jal();
        test_branches();
        test_stalls();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
